// File: Bender.yml
package:
  name: proc

sources:
  - common/proc_pkg.sv
  - fetch/instr_mem.sv
  - fetch/fetch_unit.sv
  - decode/alu_op_decode.sv
  - decode/alu_operand_decode.sv
  - verilog/reg_file.sv
  - verilog/alu.sv
  - verilog/proc.sv
  - target: test
    files:
      - tests/tb_clock.sv
      - tests/proc_tb.sv

// File: common/proc_pkg.sv
package proc_pkg;

   typedef logic [15:0] word_t;    // Data word, instruction or byte address
   typedef logic [2:0]  reg_idx_t; // One of r0..r7
   typedef logic [4:0]  opcode_t;  // Major opcode, instr[15:11]
   typedef logic [3:0]  alu_op_t;

   // Instruction field positions, LSB of each field
   localparam int OPC_LSB   = 11;
   localparam int RS_LSB    = 8;  // Also rd for LBI
   localparam int RT_LSB    = 5;  // R-format only
   localparam int RD_R_LSB  = 2;  // R-format destination
   localparam int RD_I_LSB  = 5;  // I-format destination
   localparam int FUNCT_LSB = 0;  // Two bits, picks op within a group
   localparam int IMM_LSB   = 0;  // imm5 or imm8

   // Major opcodes
   localparam opcode_t OP_HALT    = 5'b00000;
   localparam opcode_t OP_NOP     = 5'b00001;
   localparam opcode_t OP_ADDI    = 5'b01000;
   localparam opcode_t OP_SUBI    = 5'b01001;
   localparam opcode_t OP_XORI    = 5'b01010;
   localparam opcode_t OP_ANDNI   = 5'b01011;
   localparam opcode_t OP_LBI     = 5'b11000;
   localparam opcode_t OP_SHIFT_R = 5'b11010;
   localparam opcode_t OP_ARITH_R = 5'b11011;

   // ALU operations
   localparam alu_op_t ALU_ADD    = 4'h0;
   localparam alu_op_t ALU_SUB    = 4'h1; // b - a
   localparam alu_op_t ALU_XOR    = 4'h2;
   localparam alu_op_t ALU_ANDN   = 4'h3; // a & ~b
   localparam alu_op_t ALU_ROL    = 4'h4;
   localparam alu_op_t ALU_SLL    = 4'h5;
   localparam alu_op_t ALU_ROR    = 4'h6;
   localparam alu_op_t ALU_SRL    = 4'h7;
   localparam alu_op_t ALU_PASS_B = 4'h8; // LBI

endpackage

// File: decode/alu_op_decode.sv
`timescale 1ns/100ps

module alu_op_decode import proc_pkg::*; (
   input  word_t    instr,
   output alu_op_t  alu_op,
   output reg_idx_t rd_sel1,  // rs
   output reg_idx_t rd_sel2,  // rt
   output reg_idx_t wr_sel,
   output logic     wr_en,
   output logic     illegal
);

   opcode_t    opcode;
   logic [1:0] funct;

   // Arithmetic group order: ADD, SUB, XOR, ANDN
   function automatic alu_op_t arith_op(input logic [1:0] sel);
      case (sel)
         2'b00:   return ALU_ADD;
         2'b01:   return ALU_SUB;
         2'b10:   return ALU_XOR;
         default: return ALU_ANDN;
      endcase
   endfunction

   // Shift group order: ROL, SLL, ROR, SRL
   function automatic alu_op_t shift_op(input logic [1:0] sel);
      case (sel)
         2'b00:   return ALU_ROL;
         2'b01:   return ALU_SLL;
         2'b10:   return ALU_ROR;
         default: return ALU_SRL;
      endcase
   endfunction

   assign opcode  = instr[OPC_LSB +: $bits(opcode_t)];
   assign funct   = instr[FUNCT_LSB +: 2];
   assign rd_sel1 = instr[RS_LSB +: $bits(reg_idx_t)];
   assign rd_sel2 = instr[RT_LSB +: $bits(reg_idx_t)]; // Unused by I-format and LBI

   always_comb begin
      alu_op  = ALU_PASS_B;
      wr_sel  = instr[RD_R_LSB +: $bits(reg_idx_t)];
      wr_en   = 1'b0;
      illegal = 1'b0;
      case (opcode)
         OP_HALT, OP_NOP: wr_en = 1'b0; // No writeback
         OP_ARITH_R: begin
            alu_op = arith_op(funct);
            wr_en  = 1'b1;
         end
         OP_SHIFT_R: begin
            alu_op = shift_op(funct);
            wr_en  = 1'b1;
         end
         OP_ADDI, OP_SUBI, OP_XORI, OP_ANDNI: begin
            alu_op = arith_op(opcode[1:0]); // Same order as R-format arith
            wr_sel = instr[RD_I_LSB +: $bits(reg_idx_t)];
            wr_en  = 1'b1;
         end
         OP_LBI: begin
            alu_op = ALU_PASS_B;                     // Immediate straight through
            wr_sel = instr[RS_LSB +: $bits(reg_idx_t)]; // Dest sits in rs slot
            wr_en  = 1'b1;
         end
         default: illegal = 1'b1;
      endcase
   end

endmodule

// File: decode/alu_operand_decode.sv
`timescale 1ns/100ps

module alu_operand_decode import proc_pkg::*; (
   input  word_t instr,
   input  word_t rs_val,
   input  word_t rt_val,
   output word_t op_a,
   output word_t op_b
);

   opcode_t opcode;
   word_t   imm5_sext;
   word_t   imm5_zext;
   word_t   imm8_sext;

   assign opcode = instr[OPC_LSB +: $bits(opcode_t)];

   // Immediate extensions
   assign imm5_sext = {{11{instr[IMM_LSB + 4]}}, instr[IMM_LSB +: 5]};
   assign imm5_zext = {11'b0, instr[IMM_LSB +: 5]};
   assign imm8_sext = {{8{instr[IMM_LSB + 7]}}, instr[IMM_LSB +: 8]};

   assign op_a = rs_val; // Always rs

   always_comb begin
      case (opcode)
         OP_ADDI, OP_SUBI:   op_b = imm5_sext;
         OP_XORI, OP_ANDNI:  op_b = imm5_zext; // Logical ops zero extend
         OP_LBI:             op_b = imm8_sext;
         default:            op_b = rt_val;    // R-format
      endcase
   end

endmodule

// File: fetch/fetch_unit.sv
`timescale 1ns/100ps

module fetch_unit import proc_pkg::*; #(
   parameter int IMEM_WORDS = 256
) (
   input  logic  clk,
   input  logic  rst_n,
   input  logic  run,        // Low = load, high = execute
   input  logic  imem_we,
   input  word_t imem_addr,
   input  word_t imem_wdata,
   input  logic  illegal,    // From op decoder
   output word_t instr,
   output word_t pc,
   output logic  exec,       // Current instr may retire
   output logic  halted,
   output logic  err
);

   typedef enum logic [1:0] {ST_LOAD, ST_RUN, ST_HALT} state_t;

   state_t  state;
   opcode_t opcode;
   logic    load_we;
   logic    is_halt;

   assign load_we = imem_we & ~run; // Writes only accepted in load mode

   instr_mem #(.IMEM_WORDS(IMEM_WORDS)) imem_i (
      .clk   (clk),
      .we    (load_we),
      .waddr (imem_addr),
      .wdata (imem_wdata),
      .raddr (pc),
      .rdata (instr)
   );

   assign opcode  = instr[OPC_LSB +: $bits(opcode_t)];
   assign is_halt = (opcode == OP_HALT);

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         state <= ST_LOAD;
         pc    <= '0;
         err   <= 1'b0;
      end else begin
         case (state)
            ST_LOAD: begin
               pc  <= '0;
               err <= 1'b0;
               if (run) state <= ST_RUN; // First fetch from 0 next cycle
            end
            ST_RUN: begin
               if (!run) begin
                  state <= ST_LOAD;
                  pc    <= '0;
               end else if (is_halt || illegal) begin
                  state <= ST_HALT; // pc parks on the stopping instr
                  err   <= illegal;
               end else begin
                  pc <= pc + word_t'(2);
               end
            end
            ST_HALT: begin
               // Err sticky until run drops
               if (!run) begin
                  state <= ST_LOAD;
                  pc    <= '0;
                  err   <= 1'b0;
               end
            end
            default: state <= ST_LOAD;
         endcase
      end
   end

   assign exec   = (state == ST_RUN);
   assign halted = (state == ST_HALT);

   pc_even_a: assert property (@(posedge clk) disable iff (!rst_n) pc[0] == 1'b0)
      else $error("pc is odd: %h", pc);

   // Parked pc must not move while run is held
   halt_pc_a: assert property (
      @(posedge clk) disable iff (!rst_n) (state == ST_HALT && run) |=> $stable(pc)
   ) else $error("pc moved while halted");

endmodule

// File: fetch/instr_mem.sv
`timescale 1ns/100ps

module instr_mem import proc_pkg::*; #(
   parameter int IMEM_WORDS = 256  // Power of two, at least 2
) (
   input  logic  clk,
   input  logic  we,
   input  word_t waddr,
   input  word_t wdata,
   input  word_t raddr,
   output word_t rdata
);

   localparam int IDX_W = $clog2(IMEM_WORDS);

   word_t            mem [IMEM_WORDS];
   logic [IDX_W-1:0] widx;
   logic [IDX_W-1:0] ridx;

   // Byte address to word index, bit 0 dropped
   assign widx = waddr[IDX_W:1];
   assign ridx = raddr[IDX_W:1]; // Upper bits ignored, fetch wraps

   // Program load port
   always_ff @(posedge clk) begin
      if (we) begin
         mem[widx] <= wdata;
      end
   end

   assign rdata = mem[ridx]; // Combinational fetch, same cycle as pc

   // Loader must hand in aligned addresses inside the array
   waddr_ok_a: assert property (
      @(posedge clk) we |-> (waddr[0] == 1'b0) && (waddr[15:1] < IMEM_WORDS)
   ) else $error("instr_mem write to bad address %h", waddr);

endmodule

// File: proc.f
common/proc_pkg.sv
fetch/instr_mem.sv
fetch/fetch_unit.sv
decode/alu_op_decode.sv
decode/alu_operand_decode.sv
verilog/reg_file.sv
verilog/alu.sv
verilog/proc.sv
tests/tb_clock.sv
tests/proc_tb.sv

// File: tests/proc_tb.sv
`timescale 1ns/100ps

module proc_tb import proc_pkg::*; ();

   localparam int    TIMEOUT   = 200;                // Cycles per wait loop
   localparam word_t HALT_WORD = {OP_HALT, 11'd0};
   localparam word_t NOP_WORD  = {OP_NOP, 11'd0};

   logic     clk;
   logic     rst_n;
   logic     run;
   logic     imem_we;
   word_t    imem_addr;
   word_t    imem_wdata;
   word_t    pc;
   logic     halted;
   logic     err;
   logic     wb_en;
   reg_idx_t wb_reg;
   word_t    wb_data;

   word_t prog [$];       // Word i sits at byte address 2*i
   word_t model_regs [8]; // Reference register file that lives across programs
   int    errors   = 0;
   int    timeouts = 0;
   int    seed     = 58666;

   tb_clock clock_i (
      .clk   (clk),
      .rst_n (rst_n)
   );

   proc #(.IMEM_WORDS(256)) proc_i (
      .clk        (clk),
      .rst_n      (rst_n),
      .run        (run),
      .imem_we    (imem_we),
      .imem_addr  (imem_addr),
      .imem_wdata (imem_wdata),
      .pc         (pc),
      .halted     (halted),
      .err        (err),
      .wb_en      (wb_en),
      .wb_reg     (wb_reg),
      .wb_data    (wb_data)
   );

   // Instruction encoders
   function automatic word_t r_format(opcode_t opc, logic [1:0] fn, reg_idx_t rs, reg_idx_t rt,
                                      reg_idx_t rd);
      return {opc, rs, rt, rd, fn};
   endfunction

   function automatic word_t i_format(opcode_t opc, reg_idx_t rs, reg_idx_t rd, logic [4:0] imm);
      return {opc, rs, rd, imm};
   endfunction

   function automatic word_t lbi_word(reg_idx_t rd, logic [7:0] imm);
      return {OP_LBI, rd, imm};
   endfunction

   function automatic word_t arith_result(logic [1:0] fn, word_t a, word_t b);
      case (fn)
         2'd0:    return a + b;
         2'd1:    return b - a;  // rt minus rs
         2'd2:    return a ^ b;
         default: return a & ~b;
      endcase
   endfunction

   function automatic word_t shifted(logic [1:0] fn, word_t a, logic [3:0] n);
      case (fn)
         2'd0:    return (a << n) | (a >> (5'd16 - n)); // ROL
         2'd1:    return a << n;
         2'd2:    return (a >> n) | (a << (5'd16 - n)); // ROR
         default: return a >> n;
      endcase
   endfunction

   // Instruction set model stepping one instruction against model_regs
   task automatic model_step(input word_t ins, output logic we, output reg_idx_t rd,
                             output word_t val, output logic stop, output logic bad);
      opcode_t opc;
      word_t   a;
      word_t   b;
      word_t   s5;
      word_t   z5;
      opc  = ins[15:11];
      a    = model_regs[ins[10:8]]; // rs
      b    = model_regs[ins[7:5]];  // rt
      s5   = {{11{ins[4]}}, ins[4:0]};
      z5   = {11'd0, ins[4:0]};
      val  = '0;
      stop = 1'b0;
      bad  = 1'b0;
      case (opc)
         OP_HALT:    stop = 1'b1;
         OP_NOP:     val = '0;
         OP_LBI:     val = {{8{ins[7]}}, ins[7:0]};
         OP_ADDI:    val = a + s5;
         OP_SUBI:    val = s5 - a;
         OP_XORI:    val = a ^ z5;
         OP_ANDNI:   val = a & ~z5;
         OP_ARITH_R: val = arith_result(ins[1:0], a, b);
         OP_SHIFT_R: val = shifted(ins[1:0], a, b[3:0]);
         default: begin
            stop = 1'b1;
            bad  = 1'b1;
         end
      endcase
      we = !stop && (opc != OP_NOP);
      rd = ins[4:2];                       // R-format
      if (opc[4:3] == 2'b01) rd = ins[7:5]; // I-format
      if (opc == OP_LBI) rd = ins[10:8];
   endtask

   task automatic check_word(input string name, input word_t exp, input word_t got);
      if (got !== exp) begin
         errors++;
         $display("ERROR %s: expected %h got %h", name, exp, got);
      end
   endtask

   task automatic check_reg(input string name, input reg_idx_t exp, input reg_idx_t got);
      if (got !== exp) begin
         errors++;
         $display("ERROR %s: expected %h got %h", name, exp, got);
      end
   endtask

   task automatic check_bit(input string name, input logic exp, input logic got);
      if (got !== exp) begin
         errors++;
         $display("ERROR %s: expected %h got %h", name, exp, got);
      end
   endtask

   task automatic tick();
      @(posedge clk);
      #2; // Drive and sample slot
   endtask

   task automatic load_program();
      run     = 1'b0;
      imem_we = 1'b1;
      foreach (prog[i]) begin
         imem_addr  = word_t'(2 * i);
         imem_wdata = prog[i];
         tick();
      end
      imem_we = 1'b0;
   endtask

   // Run from address 0 and follow the trace until the core stops
   task automatic run_program();
      word_t    exp_pc = '0;
      int       cycles = 0;
      logic     m_we;
      reg_idx_t m_rd;
      word_t    m_val;
      logic     m_stop = 1'b0;
      logic     m_bad  = 1'b0;
      run = 1'b1;
      tick(); // LOAD to RUN
      while (!m_stop) begin
         if (cycles >= TIMEOUT || exp_pc[15:1] >= prog.size()) begin
            $display("Program did not reach HALT within %0d cycles", TIMEOUT);
            timeouts++;
            return;
         end
         if (halted) begin
            $display("Core halted early at pc %h", pc);
            errors++;
            return;
         end
         model_step(prog[exp_pc[15:1]], m_we, m_rd, m_val, m_stop, m_bad);
         check_word("pc", exp_pc, pc);
         check_bit("wb_en", m_we, wb_en);
         if (m_we) begin
            check_reg("wb_reg", m_rd, wb_reg);
            check_word("wb_data", m_val, wb_data);
            model_regs[m_rd] = m_val; // Lands on the coming edge
         end
         tick();
         cycles++;
         if (!m_stop) exp_pc += 2;
      end
      check_bit("halted", 1'b1, halted);
      check_bit("err", m_bad, err);
      check_word("pc", exp_pc, pc); // Parked on the stopping word
   endtask

   task automatic hold_halted(input word_t at, input logic exp_err);
      repeat (10) begin
         check_bit("halted", 1'b1, halted);
         check_bit("err", exp_err, err);
         check_bit("wb_en", 1'b0, wb_en);
         check_word("pc", at, pc);
         tick();
      end
   endtask

   task automatic stop_program();
      int waited = 0;
      run = 1'b0;
      tick();
      while ((halted !== 1'b0 || pc !== '0) && waited < TIMEOUT) begin
         tick();
         waited++;
      end
      if (waited >= TIMEOUT) begin
         $display("Core did not return to load mode after run dropped");
         timeouts++;
      end
      check_word("pc", '0, pc);
      check_bit("err", 1'b0, err);
   endtask

   task automatic arith_ops();
      prog = '{lbi_word(3'd1, 8'h35), lbi_word(3'd2, 8'hfd), lbi_word(3'd7, 8'h80),
               r_format(OP_ARITH_R, 2'd0, 3'd1, 3'd2, 3'd3),
               r_format(OP_ARITH_R, 2'd1, 3'd1, 3'd2, 3'd4),
               r_format(OP_ARITH_R, 2'd2, 3'd1, 3'd7, 3'd5),
               r_format(OP_ARITH_R, 2'd3, 3'd7, 3'd1, 3'd6),
               r_format(OP_ARITH_R, 2'd1, 3'd2, 3'd1, 3'd1), // r1 read and written
               HALT_WORD};
      load_program();
      run_program();
      stop_program();
   endtask

   task automatic imm_ops();
      prog = '{lbi_word(3'd1, 8'h12),
               i_format(OP_ADDI, 3'd1, 3'd2, 5'h1f), i_format(OP_ADDI, 3'd1, 3'd3, 5'h0f),
               i_format(OP_SUBI, 3'd1, 3'd4, 5'h1b), i_format(OP_SUBI, 3'd1, 3'd5, 5'h09),
               i_format(OP_XORI, 3'd1, 3'd6, 5'h1f), i_format(OP_ANDNI, 3'd1, 3'd7, 5'h10),
               lbi_word(3'd1, 8'h9c),               // Negative rs
               i_format(OP_XORI, 3'd1, 3'd2, 5'h15), i_format(OP_ANDNI, 3'd1, 3'd3, 5'h1c),
               HALT_WORD};
      load_program();
      run_program();
      stop_program();
   endtask

   task automatic shift_ops();
      // Amounts 0, 1, 8, 15 sit in the low nibble of r2..r5
      prog = '{lbi_word(3'd1, 8'ha5), lbi_word(3'd6, 8'hc3), lbi_word(3'd2, 8'h00),
               lbi_word(3'd3, 8'h31), lbi_word(3'd4, 8'h18), lbi_word(3'd5, 8'hff)};
      for (int fn = 0; fn < 4; fn++) begin
         for (int amt = 2; amt <= 5; amt++) begin
            prog.push_back(r_format(OP_SHIFT_R, 2'(fn), (fn[0] ? 3'd6 : 3'd1), 3'(amt), 3'd7));
         end
      end
      prog.push_back(HALT_WORD);
      load_program();
      run_program();
      stop_program();
   endtask

   task automatic halt_and_nop();
      prog = '{lbi_word(3'd1, 8'h07), NOP_WORD, NOP_WORD, i_format(OP_ADDI, 3'd1, 3'd2, 5'h03),
               HALT_WORD, lbi_word(3'd7, 8'h55)}; // Last word never runs
      load_program();
      run_program();
      hold_halted(16'h0008, 1'b0);
      stop_program();
   endtask

   task automatic illegal_opcode();
      prog = '{lbi_word(3'd2, 8'h44), r_format(OP_ARITH_R, 2'd0, 3'd2, 3'd2, 3'd3),
               {5'b10101, 11'h2a5}, lbi_word(3'd2, 8'h00)};
      load_program();
      run_program();
      hold_halted(16'h0004, 1'b1);
      stop_program();
      // Earlier writes survive into the next program
      prog = '{r_format(OP_ARITH_R, 2'd0, 3'd2, 3'd3, 3'd4),
               r_format(OP_ARITH_R, 2'd1, 3'd2, 3'd3, 3'd5), HALT_WORD};
      load_program();
      run_program();
      stop_program();
   endtask

   task automatic random_programs();
      logic [31:0] r;
      for (int p = 0; p < 3; p++) begin
         prog.delete();
         for (int i = 0; i < 40; i++) begin
            r = $random(seed);
            case (r[17:16])
               2'd0:    prog.push_back(lbi_word(r[10:8], r[7:0]));
               2'd1:    prog.push_back(r_format(OP_ARITH_R, r[1:0], r[10:8], r[7:5], r[4:2]));
               2'd2:    prog.push_back(r_format(OP_SHIFT_R, r[1:0], r[10:8], r[7:5], r[4:2]));
               default: prog.push_back(i_format({3'b010, r[12:11]}, r[10:8], r[7:5], r[4:0]));
            endcase
         end
         prog.push_back(HALT_WORD);
         load_program();
         run_program();
         stop_program();
      end
   endtask

   initial begin
      int waited;
      run        = 1'b0;
      imem_we    = 1'b0;
      imem_addr  = '0;
      imem_wdata = '0;
      model_regs = '{default: '0}; // Reset state
      waited     = 0;
      while (rst_n !== 1'b1 && waited < TIMEOUT) begin
         tick();
         waited++;
      end
      if (rst_n !== 1'b1) begin
         $display("Reset was never released");
         timeouts++;
      end
      if (timeouts == 0) arith_ops();
      if (timeouts == 0) imm_ops();
      if (timeouts == 0) shift_ops();
      if (timeouts == 0) halt_and_nop();
      if (timeouts == 0) illegal_opcode();
      if (timeouts == 0) random_programs();
      $display("Errors: %0d, timeouts: %0d", errors, timeouts);
      if (errors == 0 && timeouts == 0) begin
         $display("Regression passed");
      end else begin
         $display("Regression failed");
      end
      $finish;
   end

endmodule

// File: tests/tb_clock.sv
`timescale 1ns/100ps

module tb_clock #(
   parameter int HALF_PERIOD  = 10, // 20 ns clock
   parameter int RESET_CYCLES = 5
) (
   output logic clk,
   output logic rst_n
);

   initial begin
      clk = 1'b0;
      forever #(HALF_PERIOD) clk = ~clk;
   end

   // Release just after an edge, clear of the stimulus slot
   initial begin
      rst_n = 1'b0;
      repeat (RESET_CYCLES) @(posedge clk);
      #1 rst_n = 1'b1;
   end

endmodule

// File: verilog/alu.sv
`timescale 1ns/100ps

module alu import proc_pkg::*; (
   input  alu_op_t op,
   input  word_t   a,   // rs
   input  word_t   b,   // rt or immediate
   output word_t   out
);

   logic [3:0]  sh;       // Shift amount
   logic [31:0] rol_wide;
   logic [31:0] ror_wide;

   assign sh = b[3:0];

   // Rotates via doubled operand
   assign rol_wide = {a, a} << sh;
   assign ror_wide = {a, a} >> sh;

   always_comb begin
      case (op)
         ALU_ADD:    out = a + b;
         ALU_SUB:    out = b - a;   // ISA defines reversed subtract
         ALU_XOR:    out = a ^ b;
         ALU_ANDN:   out = a & ~b;
         ALU_ROL:    out = rol_wide[31:16];
         ALU_SLL:    out = a << sh;
         ALU_ROR:    out = ror_wide[15:0];
         ALU_SRL:    out = a >> sh; // Logical, zero fill
         ALU_PASS_B: out = b;
         default:    out = '0;
      endcase
   end

endmodule

// File: verilog/proc.sv
`timescale 1ns/100ps

module proc import proc_pkg::*; #(
   parameter int IMEM_WORDS = 256
) (
   input  logic     clk,
   input  logic     rst_n,
   input  logic     run,
   // Program load
   input  logic     imem_we,
   input  word_t    imem_addr,
   input  word_t    imem_wdata,
   // Status
   output word_t    pc,
   output logic     halted,
   output logic     err,
   // Retirement trace
   output logic     wb_en,
   output reg_idx_t wb_reg,
   output word_t    wb_data
);

   word_t    instr;
   logic     exec;
   alu_op_t  alu_op;
   reg_idx_t rd_sel1;
   reg_idx_t rd_sel2;
   reg_idx_t wr_sel;
   logic     wr_en;
   logic     illegal;
   word_t    rd_data1;
   word_t    rd_data2;
   word_t    op_a;
   word_t    op_b;
   word_t    alu_out;

   fetch_unit #(.IMEM_WORDS(IMEM_WORDS)) fetch_i (
      .clk        (clk),
      .rst_n      (rst_n),
      .run        (run),
      .imem_we    (imem_we),
      .imem_addr  (imem_addr),
      .imem_wdata (imem_wdata),
      .illegal    (illegal),
      .instr      (instr),
      .pc         (pc),
      .exec       (exec),
      .halted     (halted),
      .err        (err)
   );

   // Decoders run side by side on the same instr
   alu_op_decode op_dec_i (
      .instr   (instr),
      .alu_op  (alu_op),
      .rd_sel1 (rd_sel1),
      .rd_sel2 (rd_sel2),
      .wr_sel  (wr_sel),
      .wr_en   (wr_en),
      .illegal (illegal)
   );

   alu_operand_decode opnd_dec_i (
      .instr  (instr),
      .rs_val (rd_data1),
      .rt_val (rd_data2),
      .op_a   (op_a),
      .op_b   (op_b)
   );

   reg_file rf_i (
      .clk      (clk),
      .rst_n    (rst_n),
      .rd_sel1  (rd_sel1),
      .rd_sel2  (rd_sel2),
      .wr_sel   (wr_sel),
      .wr_data  (alu_out),
      .wr_en    (wb_en),
      .rd_data1 (rd_data1),
      .rd_data2 (rd_data2)
   );

   alu alu_i (
      .op  (alu_op),
      .a   (op_a),
      .b   (op_b),
      .out (alu_out)
   );

   // Writeback only while executing, trace mirrors the write port
   assign wb_en   = wr_en & exec;
   assign wb_reg  = wr_sel;
   assign wb_data = alu_out;

endmodule

// File: verilog/reg_file.sv
`timescale 1ns/100ps

module reg_file import proc_pkg::*; (
   input  logic     clk,
   input  logic     rst_n,
   input  reg_idx_t rd_sel1,
   input  reg_idx_t rd_sel2,
   input  reg_idx_t wr_sel,
   input  word_t    wr_data,
   input  logic     wr_en,
   output word_t    rd_data1,
   output word_t    rd_data2
);

   localparam int NUM_REGS = 2 ** $bits(reg_idx_t);

   word_t regs [NUM_REGS];

   // Write on edge, all registers cleared by reset
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         regs <= '{default: '0};
      end else if (wr_en) begin
         regs[wr_sel] <= wr_data;
      end
   end

   // Reads see the old value, new data lands at the edge
   assign rd_data1 = regs[rd_sel1];
   assign rd_data2 = regs[rd_sel2];

   // An X result here points back at decode or an unloaded memory word
   wr_data_known_a: assert property (
      @(posedge clk) disable iff (!rst_n) wr_en |-> !$isunknown(wr_data)
   ) else $error("reg_file write of unknown data to r%0d", wr_sel);

endmodule
